// File: src.f
verilog/sobel_pkg.sv
verilog/line_buffer.sv
verilog/sobel_kernel.sv
verilog/sync_delayer.sv
verilog/sobel_top.sv
verification/sobel_assert.sv
verification/tb_sobel.sv

// File: Makefile
TOP = tb_sobel

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_sobel.sv
/*
 * testbench for the sobel edge filter top level
 * clock, reset, frame stimulus with random blanking
 * reference sobel model, output compare process, watchdog
 */

`timescale 1ns/1ps

module tb_sobel import sobel_pkg::*; ();

    localparam int NUM_FRAMES   = 5;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 6;
    // row blanking and frame gap both drawn from 2 to 6
    localparam int MAX_BLANK    = 6;
    localparam int MAX_GAP      = 6;
    // fsync lead clock plus trailing clock per frame
    localparam int FRAME_EDGE   = 2;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * IMG_ROWS * (IMG_COLS + MAX_BLANK)
                                  + NUM_FRAMES * (MAX_GAP + FRAME_EDGE))
                                  + RESET_CYCLES + IDLE_CYCLES;

    logic   clk;
    logic   rst;
    logic   fsync_in;
    logic   rsync_in;
    pixel_t pixel_in;
    logic   fsync_out;
    logic   rsync_out;
    pixel_t pixel_out;

    // stimulus frames indexed [frame][row][col]
    pixel_t frames [NUM_FRAMES][IMG_ROWS][IMG_COLS];
    int     seed;
    // output frames whose fsync_out has ended
    int     frames_seen;

    sobel_top uut (
        .clk       (clk),
        .rst       (rst),
        .fsync_in  (fsync_in),
        .rsync_in  (rsync_in),
        .pixel_in  (pixel_in),
        .fsync_out (fsync_out),
        .rsync_out (rsync_out),
        .pixel_out (pixel_out)
    );

    bind sobel_top sobel_assert u_sobel_assert (
        .clk       (clk),
        .rst       (rst),
        .rsync_in  (rsync_in),
        .fsync_out (fsync_out),
        .rsync_out (rsync_out),
        .pixel_out (pixel_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp,
                               input int row, input int col);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%02h expected 0x%02h at row %0d col %0d",
                     name, got, exp, row, col);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // zero on the two border columns, else min(255, |gx|+|gy|) over rows row-2..row
    function automatic pixel_t sobel_ref(input int frame, input int row, input int col);
        int p [3][3];
        int gx;
        int gy;
        int sum;
        if (col < 2) begin
            return '0;
        end
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                p[r][c] = int'(frames[frame][row-2+r][col-2+c]);
            end
        end
        gx = (p[0][2] + 2 * p[1][2] + p[2][2]) - (p[0][0] + 2 * p[1][0] + p[2][0]);
        gy = (p[2][0] + 2 * p[2][1] + p[2][2]) - (p[0][0] + 2 * p[0][1] + p[0][2]);
        if (gx < 0) gx = -gx;
        if (gy < 0) gy = -gy;
        sum = gx + gy;
        if (sum > 255) sum = 255;
        return pixel_t'(sum);
    endfunction

    // frame 1 stripes, frame 2 hard edge at the left border, rest random
    task automatic fill_frames();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int r = 0; r < IMG_ROWS; r++) begin
                for (int c = 0; c < IMG_COLS; c++) begin
                    if (f == 1 && r < IMG_ROWS / 2) begin
                        // vertical stripes two columns wide
                        frames[f][r][c] = (((c >> 1) & 1) == 1) ? 8'hff : 8'h00;
                    end else if (f == 1) begin
                        // horizontal stripes two rows high
                        frames[f][r][c] = (((r >> 1) & 1) == 1) ? 8'hff : 8'h00;
                    end else if (f == 2) begin
                        frames[f][r][c] = (c < 2) ? 8'hff : 8'h00;
                    end else begin
                        frames[f][r][c] = pixel_t'($random(seed));
                    end
                end
            end
        end
    endtask

    // fsync leads the frame by a clock and trails the last blanking by one
    task automatic drive_frame(input int f);
        int blank;
        int gap;
        @(negedge clk);
        fsync_in = 1'b1;
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                @(negedge clk);
                rsync_in = 1'b1;
                pixel_in = frames[f][r][c];
            end
            blank = 2 + int'($unsigned($random(seed)) % 5);
            for (int b = 0; b < blank; b++) begin
                @(negedge clk);
                rsync_in = 1'b0;
                pixel_in = '0;
            end
        end
        @(negedge clk);
        fsync_in = 1'b0;
        gap = 2 + int'($unsigned($random(seed)) % 5);
        repeat (gap) @(negedge clk);
    endtask

    initial begin : stimulus
        seed        = 32'h0168_6bf7;
        frames_seen = 0;
        rst         = 1'b1;
        fsync_in    = 1'b0;
        rsync_in    = 1'b0;
        pixel_in    = '0;
        fill_frames();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // outputs must stay at zero through the quiet stretch
        repeat (IDLE_CYCLES) @(negedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            drive_frame(f);
        end
        wait (frames_seen == NUM_FRAMES);
        // outputs stay idle after the last frame
        repeat (4) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin : compare
        // input info history with the oldest entry at index PIPE_CLKS-1
        logic   rs_d  [PIPE_CLKS];
        int     row_d [PIPE_CLKS];
        int     col_d [PIPE_CLKS];
        int     frm_d [PIPE_CLKS];
        logic   rs_in_prev;
        logic   fs_in_prev;
        int     in_row_next;
        int     in_col_next;
        int     in_row;
        int     in_col;
        int     in_frame;
        logic   rs_out_prev;
        logic   fs_out_prev;
        int     prev_row;
        logic   fs_exp;
        logic   drop_next;
        int     rows_in_fs;
        int     cols_in_rs;
        pixel_t pix_exp;
        for (int i = 0; i < PIPE_CLKS; i++) begin
            rs_d[i]  = 1'b0;
            row_d[i] = 0;
            col_d[i] = 0;
            frm_d[i] = 0;
        end
        rs_in_prev  = 1'b0;
        fs_in_prev  = 1'b0;
        in_row_next = 0;
        in_col_next = 0;
        in_row      = 0;
        in_col      = 0;
        in_frame    = 0;
        rs_out_prev = 1'b0;
        fs_out_prev = 1'b0;
        prev_row    = 0;
        fs_exp      = 1'b0;
        drop_next   = 1'b0;
        rows_in_fs  = 0;
        cols_in_rs  = 0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            // outputs seen here belong to the input sampled PIPE_CLKS edges ago
            check_bit("rsync_out", rsync_out, rs_d[PIPE_CLKS-1]);

            // fsync rises with row WIN_ROWS-1 and drops a clock after the last row
            if (drop_next) fs_exp = 1'b0;
            drop_next = 1'b0;
            if (rs_d[PIPE_CLKS-1] && !rs_out_prev && row_d[PIPE_CLKS-1] == WIN_ROWS - 1)
                fs_exp = 1'b1;
            if (!rs_d[PIPE_CLKS-1] && rs_out_prev && prev_row == IMG_ROWS - 1)
                drop_next = 1'b1;
            check_bit("fsync_out", fsync_out, fs_exp);

            // rows without a full window are only checked on the border
            if (rs_d[PIPE_CLKS-1] && row_d[PIPE_CLKS-1] >= WIN_ROWS - 1) begin
                pix_exp = sobel_ref(frm_d[PIPE_CLKS-1], row_d[PIPE_CLKS-1],
                                    col_d[PIPE_CLKS-1]);
                check_pixel("pixel_out", pixel_out, pix_exp,
                            row_d[PIPE_CLKS-1], col_d[PIPE_CLKS-1]);
            end else if (rs_d[PIPE_CLKS-1] && col_d[PIPE_CLKS-1] < WIN_ROWS - 1) begin
                check_pixel("pixel_out", pixel_out, '0,
                            row_d[PIPE_CLKS-1], col_d[PIPE_CLKS-1]);
            end else if (!rs_d[PIPE_CLKS-1]) begin
                check_pixel("pixel_out", pixel_out, '0, -1, -1);
            end

            // row length and rows per frame
            if (rsync_out) cols_in_rs++;
            if (!rsync_out && rs_out_prev) begin
                check_count("rsync_out high clocks", cols_in_rs, IMG_COLS);
                cols_in_rs = 0;
            end
            if (rsync_out && !rs_out_prev && fsync_out) rows_in_fs++;
            if (!fsync_out && fs_out_prev) begin
                check_count("rows under fsync_out", rows_in_fs, IMG_ROWS - WIN_ROWS + 1);
                rows_in_fs = 0;
                frames_seen++;
            end
            rs_out_prev = rsync_out;
            fs_out_prev = fsync_out;
            prev_row    = row_d[PIPE_CLKS-1];

            for (int i = PIPE_CLKS - 1; i > 0; i--) begin
                rs_d[i]  = rs_d[i-1];
                row_d[i] = row_d[i-1];
                col_d[i] = col_d[i-1];
                frm_d[i] = frm_d[i-1];
            end

            // row and column of the input pixel sampled at this edge
            if (!fsync_in) in_row_next = 0;
            if (!fsync_in && fs_in_prev) in_frame++;
            if (rsync_in && !rs_in_prev) begin
                in_row = in_row_next;
                in_row_next++;
            end
            if (rsync_in) begin
                in_col = in_col_next;
                in_col_next++;
            end else begin
                in_col_next = 0;
            end
            rs_d[0]  = rsync_in;
            row_d[0] = in_row;
            col_d[0] = in_col;
            frm_d[0] = in_frame;
            rs_in_prev = rsync_in;
            fs_in_prev = fsync_in;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: only %0d of %0d frames finished after %0d cycles",
                         frames_seen, NUM_FRAMES, cycles);
                stop_on_error();
            end
        end
    end

endmodule

// File: verification/sobel_assert.sv
/*
 * concurrent assertions on the sync timing of the sobel top level
 * rsync delay, fsync rise alignment, black pixels outside rows
 */

`timescale 1ns/1ps

module sobel_assert import sobel_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   rsync_in,
    input logic   fsync_out,
    input logic   rsync_out,
    input pixel_t pixel_out
);

    // output row sync is the input row sync, pipeline clocks late
    property rsync_delayed;
        @(posedge clk) disable iff (rst)
            rsync_out == $past(rsync_in, PIPE_CLKS);
    endproperty

    // fsync_out only starts together with a row
    property fsync_rise_in_row;
        @(posedge clk) disable iff (rst)
            $rose(fsync_out) |-> rsync_out;
    endproperty

    // blanking carries black pixels
    property black_outside_row;
        @(posedge clk) disable iff (rst)
            !rsync_out |-> (pixel_out == '0);
    endproperty

    a_rsync_delayed: assert property (rsync_delayed)
        else $error("rsync_out does not follow rsync_in two clocks later");

    a_fsync_rise_in_row: assert property (fsync_rise_in_row)
        else $error("fsync_out rose while rsync_out was low");

    a_black_outside_row: assert property (black_outside_row)
        else $error("pixel_out is not zero while rsync_out is low");

endmodule

// File: verilog/sobel_top.sv
/*
 * sobel edge filter top level
 * line buffer, kernel and sync delayer on the video stream
 */

`timescale 1ns/1ps

module sobel_top import sobel_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fsync_in,
    input  logic   rsync_in,
    input  pixel_t pixel_in,
    output logic   fsync_out,
    output logic   rsync_out,
    output pixel_t pixel_out
);

    // one column of the 3x3 window
    pixel_t tap_top;
    pixel_t tap_mid;
    pixel_t tap_bot;

    // input side, row history
    line_buffer u_line_buffer (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (pixel_in),
        .rsync_in (rsync_in),
        .tap_top  (tap_top),
        .tap_mid  (tap_mid),
        .tap_bot  (tap_bot)
    );

    // two-clock gradient pipeline
    sobel_kernel u_sobel_kernel (
        .clk       (clk),
        .rst       (rst),
        .tap_top   (tap_top),
        .tap_mid   (tap_mid),
        .tap_bot   (tap_bot),
        .rsync_in  (rsync_in),
        .pixel_out (pixel_out)
    );

    // output side, sync aligned to pixel_out
    sync_delayer u_sync_delayer (
        .clk       (clk),
        .rst       (rst),
        .fsync_in  (fsync_in),
        .rsync_in  (rsync_in),
        .fsync_out (fsync_out),
        .rsync_out (rsync_out)
    );

endmodule

// File: verilog/sync_delayer.sv
/*
 * rsync delay matching the kernel pipeline
 * delayed row counter and regenerated fsync
 * covering only rows with a full window
 */

`timescale 1ns/1ps

module sync_delayer import sobel_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fsync_in,
    input  logic rsync_in,
    output logic fsync_out,
    output logic rsync_out
);

    // rsync delay line plus one history stage for edge detection
    logic [PIPE_CLKS:0] rsync_pipe;

    // delayed rows started so far in this frame
    logic [ROW_W-1:0] row_cnt;

    logic rise_next;
    logic fall_now;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsync_pipe <= '0;
        end else begin
            rsync_pipe <= {rsync_pipe[PIPE_CLKS-1:0], rsync_in};
        end
    end

    assign rsync_out = rsync_pipe[PIPE_CLKS-1];

    // delayed rsync goes high on the next clock
    assign rise_next = rsync_pipe[PIPE_CLKS-2] && !rsync_pipe[PIPE_CLKS-1];
    // delayed rsync has just gone low
    assign fall_now  = rsync_pipe[PIPE_CLKS] && !rsync_pipe[PIPE_CLKS-1];

    // row counter, held at zero between frames
    always_ff @(posedge clk) begin
        if (rst || !fsync_in) begin
            row_cnt <= '0;
        end else if (rise_next && row_cnt != ROW_W'(IMG_ROWS)) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // fsync rises together with delayed row WIN_ROWS-1
    // and drops one clock after delayed row IMG_ROWS-1 ends
    always_ff @(posedge clk) begin
        if (rst) begin
            fsync_out <= 1'b0;
        end else if (fsync_in && rise_next && row_cnt == ROW_W'(WIN_ROWS - 1)) begin
            fsync_out <= 1'b1;
        end else if (fall_now && row_cnt == ROW_W'(IMG_ROWS)) begin
            fsync_out <= 1'b0;
        end
    end

endmodule

// File: verilog/sobel_kernel.sv
/*
 * 3x3 window registers and column counter
 * sobel gradient sums, saturated |gx|+|gy| magnitude
 * border columns and blanking forced to zero
 */

`timescale 1ns/1ps

module sobel_kernel import sobel_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  pixel_t tap_top,
    input  pixel_t tap_mid,
    input  pixel_t tap_bot,
    input  logic   rsync_in,
    output pixel_t pixel_out
);

    // window, index [row][col], row 0 on top, col 2 newest
    pixel_t win [WIN_ROWS][WIN_ROWS];

    // column of the incoming tap within its row
    logic [COL_W-1:0] col_cnt;

    // stage 1 flags that travel with the window
    logic win_valid;
    logic win_border;

    // stage 2 combinational terms
    logic signed [GRAD_W-1:0] gx;
    logic signed [GRAD_W-1:0] gy;
    logic        [GRAD_W-1:0] gx_abs;
    logic        [GRAD_W-1:0] gy_abs;
    logic        [GRAD_W:0]   mag_sum;
    pixel_t                   mag_sat;

    // zero-extend a pixel into the signed gradient width
    function automatic logic signed [GRAD_W-1:0] ext(input pixel_t p);
        ext = $signed({{(GRAD_W-PIX_W){1'b0}}, p});
    endfunction

    // column counter clears during row blanking
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
        end else if (rsync_in) begin
            col_cnt <= col_cnt + 1'b1;
        end else begin
            col_cnt <= '0;
        end
    end

    // stage 1, shift a new tap column into the window
    always_ff @(posedge clk) begin
        if (rsync_in) begin
            for (int r = 0; r < WIN_ROWS; r++) begin
                for (int c = 0; c < WIN_ROWS - 1; c++) begin
                    win[r][c] <= win[r][c+1];
                end
            end
            win[0][WIN_ROWS-1] <= tap_top;
            win[1][WIN_ROWS-1] <= tap_mid;
            win[2][WIN_ROWS-1] <= tap_bot;
        end
    end

    // stage 1 control, valid bit and border flag
    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid  <= 1'b0;
            win_border <= 1'b0;
        end else begin
            win_valid  <= rsync_in;
            // right column 0 or 1 means the window wraps into the previous row
            win_border <= (col_cnt < COL_W'(WIN_ROWS - 1));
        end
    end

    // standard sobel weights
    // gx = right column minus left column, middle row doubled
    // gy = bottom row minus top row, middle column doubled
    always_comb begin
        gx = ext(win[0][2]) + (ext(win[1][2]) <<< 1) + ext(win[2][2])
           - ext(win[0][0]) - (ext(win[1][0]) <<< 1) - ext(win[2][0]);
        gy = ext(win[2][0]) + (ext(win[2][1]) <<< 1) + ext(win[2][2])
           - ext(win[0][0]) - (ext(win[0][1]) <<< 1) - ext(win[0][2]);

        gx_abs = gx[GRAD_W-1] ? GRAD_W'(-gx) : GRAD_W'(gx);
        gy_abs = gy[GRAD_W-1] ? GRAD_W'(-gy) : GRAD_W'(gy);

        // one extra bit, worst case is 2040
        mag_sum = {1'b0, gx_abs} + {1'b0, gy_abs};

        // clamp to the pixel range
        if (mag_sum > (GRAD_W+1)'(PIX_MAX)) begin
            mag_sat = pixel_t'(PIX_MAX);
        end else begin
            mag_sat = mag_sum[PIX_W-1:0];
        end
    end

    // stage 2, magnitude register
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_out <= '0;
        end else if (win_valid && !win_border) begin
            pixel_out <= mag_sat;
        end else begin
            // blanking and border columns read as black
            pixel_out <= '0;
        end
    end

endmodule

// File: verilog/line_buffer.sv
/*
 * two cascaded row-length shift registers
 * gives three vertically aligned taps per valid pixel
 */

`timescale 1ns/1ps

module line_buffer import sobel_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  pixel_t pixel_in,
    input  logic   rsync_in,
    output pixel_t tap_top,
    output pixel_t tap_mid,
    output pixel_t tap_bot
);

    // row_mid holds the last IMG_COLS valid pixels
    // its oldest entry is the same column one row up
    pixel_t row_mid [IMG_COLS];
    // row_top is fed from row_mid, so two rows up
    pixel_t row_top [IMG_COLS];

    always_ff @(posedge clk) begin
        if (rst) begin
            // stream start sees black rows above the first one
            for (int i = 0; i < IMG_COLS; i++) begin
                row_mid[i] <= '0;
                row_top[i] <= '0;
            end
        end else if (rsync_in) begin
            // advance only on valid pixels, blanking leaves rows intact
            row_mid[0] <= pixel_in;
            row_top[0] <= row_mid[IMG_COLS-1];
            for (int i = 1; i < IMG_COLS; i++) begin
                row_mid[i] <= row_mid[i-1];
                row_top[i] <= row_top[i-1];
            end
        end
    end

    // taps are combinational, bottom is the live pixel
    assign tap_bot = pixel_in;
    assign tap_mid = row_mid[IMG_COLS-1];
    assign tap_top = row_top[IMG_COLS-1];

endmodule

// File: verilog/sobel_pkg.sv
/*
 * shared definitions for the sobel edge filter
 * image geometry, pixel and gradient widths, counter widths
 * pipeline depth and window size, pixel type
 */

package sobel_pkg;

    // active image geometry
    localparam int IMG_COLS = 16;
    localparam int IMG_ROWS = 10;

    // data widths
    localparam int PIX_W  = 8;
    // signed gradient sum, covers +-1020
    localparam int GRAD_W = 11;
    localparam int PIX_MAX = (1 << PIX_W) - 1;

    // counter widths, one extra value for the terminal count
    localparam int COL_W = $clog2(IMG_COLS + 1);
    localparam int ROW_W = $clog2(IMG_ROWS + 1);

    // clocks from pixel in to result out
    localparam int PIPE_CLKS = 2;
    // window height, also its width
    localparam int WIN_ROWS  = 3;

    typedef logic [PIX_W-1:0] pixel_t;

endpackage
